// File: Makefile
TOOL  = verilator
FLAGS = --timing
TOP   = tb_i8008
FLIST = flist.f
BUILD = build

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf $(BUILD)

// File: design/alu.sv
`timescale 1ns/10ps

module alu import i8008_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] a,
  input  logic [7:0] b,
  input  logic       use_rot,
  input  alu_op_t    alu_op,
  input  rot_op_t    rot_op,
  input  logic       flag_we,
  output logic [7:0] y,
  output logic       carry
);

  logic       cin;
  logic [8:0] sum;
  logic [8:0] diff;
  logic       carry_next;

  // Carry only enters ADC and SBB
  assign cin  = carry & (alu_op == ALU_ADC || alu_op == ALU_SBB);
  assign sum  = {1'b0, a} + {1'b0, b} + {8'd0, cin};
  assign diff = {1'b0, a} - {1'b0, b} - {8'd0, cin};  // Bit 8 is the borrow

  always_comb begin
    y = a;
    carry_next = carry;
    if (use_rot) begin
      case (rot_op)
        ROT_INC: y = a + 8'd1;  // Carry untouched
        ROT_DEC: y = a - 8'd1;
        ROT_RLC: begin
          y = {a[6:0], a[7]};
          carry_next = a[7];
        end
        ROT_RRC: begin
          y = {a[0], a[7:1]};
          carry_next = a[0];
        end
        ROT_RAL: begin
          y = {a[6:0], carry};  // Through the carry
          carry_next = a[7];
        end
        ROT_RAR: begin
          y = {carry, a[7:1]};
          carry_next = a[0];
        end
        default: y = a;
      endcase
    end else begin
      case (alu_op)
        ALU_ADD, ALU_ADC: begin
          y = sum[7:0];
          carry_next = sum[8];
        end
        ALU_SUB, ALU_SBB: begin
          y = diff[7:0];
          carry_next = diff[8];
        end
        ALU_AND: begin
          y = a & b;
          carry_next = 1'b0;
        end
        ALU_XOR: begin
          y = a ^ b;
          carry_next = 1'b0;
        end
        ALU_OR: begin
          y = a | b;
          carry_next = 1'b0;
        end
        ALU_CMP: carry_next = diff[8];  // y stays a
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      carry <= 1'b0;
    end else if (flag_we) begin
      carry <= carry_next;
    end
  end

endmodule

// File: design/cycle_sequencer.sv
`timescale 1ns/10ps

module cycle_sequencer import i8008_pkg::*; #(
  parameter int READY_SYNC_STAGES = 2
) (
  input  logic        clk,
  input  logic        rst,
  input  logic [7:0]  d_in,
  input  logic        ready,
  input  logic [7:0]  addr_byte,
  output logic [7:0]  d_out,
  output logic        sync,
  output state_t      state,
  output logic        pc_inc,
  output logic        pc_hi_sel,
  output cycle_type_t cyc_type,
  exec_if.seq         ex
);

  logic [READY_SYNC_STAGES-1:0] ready_sync;
  logic       ready_s;
  logic [7:0] ir;
  logic [7:0] opc;     // Opcode being decoded
  logic [7:0] din_q;
  cycle_t     cycle;
  state_t     next_state;
  cycle_t     next_cycle;
  logic       wr_cyc;
  reg_sel_t   ddd;
  reg_sel_t   sss;
  logic       is_lrr, is_lmr, is_lri, is_alu, is_inr, is_dcr, is_rot, is_hlt;

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_sync <= '0;
    end else begin
      ready_sync[0] <= ready;
      for (int i = 1; i < READY_SYNC_STAGES; i++) begin
        ready_sync[i] <= ready_sync[i-1];
      end
    end
  end

  assign ready_s = ready_sync[READY_SYNC_STAGES-1];

  // At T3 of cycle 1 the opcode is still on d_in
  assign opc = (state == T3 && cycle == CYCLE1) ? d_in : ir;
  assign ddd = reg_sel_t'(opc[5:3]);
  assign sss = reg_sel_t'(opc[2:0]);

  assign is_hlt = opc == OP_HLT || opc[7:1] == 7'd0;
  assign is_lmr = (opc & MASK_SRC) == OP_LMR && sss != REG_M;
  assign is_lrr = opc[7:6] == OP_LRR[7:6] && ddd != REG_M && sss != REG_M;
  assign is_alu = opc[7:6] == OP_ALU[7:6] && sss != REG_M;
  assign is_lri = (opc & MASK_DST) == OP_LRI && ddd != REG_M;
  assign is_inr = (opc & MASK_DST) == OP_INR && ddd != REG_A && ddd != REG_M;
  assign is_dcr = (opc & MASK_DST) == OP_DCR && ddd != REG_A && ddd != REG_M;
  assign is_rot = (opc & MASK_ROT) == OP_ROT;

  assign wr_cyc    = cycle == CYCLE2 && is_lmr;
  assign cyc_type  = (cycle == CYCLE1) ? PCI : (is_lmr ? PCW : PCR);
  assign pc_hi_sel = state == T2;
  assign pc_inc    = state == T2 && !wr_cyc;  // Fetch or immediate read

  always_comb begin
    next_state = state;
    next_cycle = cycle;
    case (state)
      T1: next_state = T2;
      T2, WAIT: next_state = ready_s ? T3 : WAIT;
      T3: begin
        if (cycle != CYCLE1) begin
          next_state = is_lmr ? T1 : T4;  // Store done, or LrI goes on
          next_cycle = is_lmr ? CYCLE1 : CYCLE2;
        end else if (is_hlt) begin
          next_state = STOPPED;
        end else if (is_lri) begin
          next_state = T1;
          next_cycle = CYCLE2;
        end else if (is_lrr || is_lmr || is_alu || is_inr || is_dcr || is_rot) begin
          next_state = T4;
        end else begin
          next_state = T1;  // Unkept opcode
        end
      end
      T4: begin
        if (cycle == CYCLE1 && is_lmr) begin
          next_state = T1;
          next_cycle = CYCLE2;
        end else begin
          next_state = T5;
        end
      end
      T5: begin
        next_state = T1;
        next_cycle = CYCLE1;
      end
      STOPPED: next_state = STOPPED;  // Left only by reset
      default: begin
        next_state = T1;
        next_cycle = CYCLE1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T1;
      cycle <= CYCLE1;
      sync  <= 1'b0;
      ir    <= 8'h00;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
      sync  <= next_state == T1;
      if (state == T3 && cycle == CYCLE1) begin
        ir <= d_in;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == T3 && !wr_cyc) begin
      din_q <= d_in;
    end
  end

  assign ex.din = din_q;

  always_comb begin
    ex.rd_sel  = REG_A;
    ex.wr_sel  = ddd;
    ex.reg_we  = 1'b0;
    ex.a_we    = 1'b0;
    ex.b_we    = 1'b0;
    ex.bus_src = BUS_DIN;
    ex.use_rot = 1'b0;
    ex.alu_op  = alu_op_t'(opc[5:3]);
    ex.rot_op  = rot_op_t'(opc[5:3]);
    ex.flag_we = 1'b0;
    case (state)
      T1: begin
        if (wr_cyc) begin
          ex.rd_sel  = REG_L;
          ex.bus_src = BUS_REG;
        end
      end
      T2: begin
        if (wr_cyc) begin
          ex.rd_sel  = REG_H;
          ex.bus_src = BUS_REG;
        end
      end
      T3: begin
        if (wr_cyc) begin
          ex.bus_src = BUS_TMPB;  // Store data
        end else if (cycle == CYCLE1) begin
          ex.bus_src = BUS_REG;   // Accumulator into temp A
          ex.a_we    = 1'b1;
        end
      end
      T4: begin
        if (cycle == CYCLE1 && (is_inr || is_dcr)) begin
          ex.rd_sel  = ddd;
          ex.bus_src = BUS_REG;
          ex.a_we    = 1'b1;
        end else if (cycle == CYCLE1 && (is_lrr || is_alu || is_lmr)) begin
          ex.rd_sel  = sss;
          ex.bus_src = BUS_REG;
          ex.b_we    = 1'b1;
        end
      end
      T5: begin
        if (cycle == CYCLE2) begin
          ex.reg_we = 1'b1;  // LrI operand
        end else if (is_lrr) begin
          ex.bus_src = BUS_TMPB;
          ex.reg_we  = 1'b1;
        end else if (is_alu || is_rot) begin
          ex.use_rot = is_rot;
          ex.bus_src = BUS_ALU;
          ex.wr_sel  = REG_A;
          ex.reg_we  = 1'b1;
          ex.flag_we = 1'b1;
        end else if (is_inr || is_dcr) begin
          ex.use_rot = 1'b1;
          ex.rot_op  = is_inr ? ROT_INC : ROT_DEC;
          ex.bus_src = BUS_ALU;
          ex.reg_we  = 1'b1;
        end
      end
      default: ;
    endcase
  end

  // Write cycles put H:L and the data on d_out instead of the PC
  always_comb begin
    case (state)
      T1: d_out = wr_cyc ? ex.result : addr_byte;
      T2: d_out = wr_cyc ? {PCW, ex.result[5:0]} : addr_byte;
      T3: d_out = wr_cyc ? ex.result : 8'h00;
      default: d_out = 8'h00;
    endcase
  end

  assert property (@(posedge clk) disable iff (rst)
    state inside {T1, T2, WAIT, T3, T4, T5, STOPPED})
    else $error("cycle_sequencer: illegal state encoding");

endmodule

// File: design/exec_if.sv
`timescale 1ns/10ps

interface exec_if import i8008_pkg::*; ();

  reg_sel_t   rd_sel;
  reg_sel_t   wr_sel;
  logic       reg_we;
  logic       a_we;
  logic       b_we;
  bus_src_t   bus_src;
  logic       use_rot;  // Single-operand path of the ALU
  alu_op_t    alu_op;
  rot_op_t    rot_op;
  logic       flag_we;
  logic [7:0] din;      // Byte latched from d_in at T3
  logic [7:0] result;   // Internal bus byte

  modport seq (output rd_sel, wr_sel, reg_we, a_we, b_we, bus_src, use_rot,
               output alu_op, rot_op, flag_we, din, input result);

  modport exec (input rd_sel, wr_sel, reg_we, a_we, b_we, bus_src, use_rot,
                input alu_op, rot_op, flag_we, din, output result);

endinterface

// File: design/exec_unit.sv
`timescale 1ns/10ps

module exec_unit import i8008_pkg::*; (
  input logic  clk,
  input logic  rst,
  exec_if.exec ex
);

  logic [7:0] tmp_a;    // Accumulator or INr/DCr/rotate target
  logic [7:0] tmp_b;    // Source register or store data
  logic [7:0] rd_data;
  logic [7:0] alu_y;
  logic [7:0] bus;

  always_ff @(posedge clk) begin
    if (ex.a_we) begin
      tmp_a <= bus;
    end
    if (ex.b_we) begin
      tmp_b <= bus;
    end
  end

  always_comb begin
    case (ex.bus_src)
      BUS_DIN:  bus = ex.din;
      BUS_REG:  bus = rd_data;
      BUS_TMPB: bus = tmp_b;
      BUS_ALU:  bus = alu_y;
    endcase
  end

  assign ex.result = bus;

  reg_file rf_i (
    .clk,
    .rst,
    .we      (ex.reg_we),
    .wr_sel  (ex.wr_sel),
    .rd_sel  (ex.rd_sel),
    .wr_data (bus),
    .rd_data (rd_data)
  );

  alu alu_i (
    .clk,
    .rst,
    .a       (tmp_a),
    .b       (tmp_b),
    .use_rot (ex.use_rot),
    .alu_op  (ex.alu_op),
    .rot_op  (ex.rot_op),
    .flag_we (ex.flag_we),
    .y       (alu_y),
    .carry   ()
  );

endmodule

// File: design/i8008_pkg.sv
package i8008_pkg;

  localparam int ADDR_WIDTH = 14;

  // Timing states of one machine cycle
  typedef enum logic [2:0] {
    T1      = 3'd0,
    T2      = 3'd1,
    WAIT    = 3'd2,
    T3      = 3'd3,
    T4      = 3'd4,
    T5      = 3'd5,
    STOPPED = 3'd6
  } state_t;

  typedef enum logic [1:0] {
    CYCLE1 = 2'd0,
    CYCLE2 = 2'd1,
    CYCLE3 = 2'd2  // Encoding only
  } cycle_t;

  // Sent in bits 7:6 of the high address byte
  typedef enum logic [1:0] {
    PCI = 2'b00,
    PCC = 2'b01,
    PCR = 2'b10,
    PCW = 2'b11
  } cycle_type_t;

  // Same as instruction bits 5:3 of the ALU group
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_ADC = 3'd1,
    ALU_SUB = 3'd2,
    ALU_SBB = 3'd3,
    ALU_AND = 3'd4,
    ALU_XOR = 3'd5,
    ALU_OR  = 3'd6,
    ALU_CMP = 3'd7
  } alu_op_t;

  typedef enum logic [2:0] {
    ROT_RLC = 3'd0,  // Rotates match instruction bits 5:3
    ROT_RRC = 3'd1,
    ROT_RAL = 3'd2,
    ROT_RAR = 3'd3,
    ROT_INC = 3'd4,
    ROT_DEC = 3'd5
  } rot_op_t;

  typedef enum logic [2:0] {
    REG_A = 3'd0,
    REG_B = 3'd1,
    REG_C = 3'd2,
    REG_D = 3'd3,
    REG_E = 3'd4,
    REG_H = 3'd5,
    REG_L = 3'd6,
    REG_M = 3'd7
  } reg_sel_t;

  // Internal data bus sources
  typedef enum logic [1:0] {
    BUS_DIN  = 2'd0,
    BUS_REG  = 2'd1,
    BUS_TMPB = 2'd2,
    BUS_ALU  = 2'd3
  } bus_src_t;

  // Opcode bases with their field bits cleared
  localparam logic [7:0] OP_LRR = 8'hC0;  // 11 DDD SSS
  localparam logic [7:0] OP_LMR = 8'hF8;  // 11 111 SSS
  localparam logic [7:0] OP_LRI = 8'h06;  // 00 DDD 110
  localparam logic [7:0] OP_ALU = 8'h80;  // 10 PPP SSS
  localparam logic [7:0] OP_INR = 8'h00;  // 00 DDD 000
  localparam logic [7:0] OP_DCR = 8'h01;  // 00 DDD 001
  localparam logic [7:0] OP_ROT = 8'h02;  // 00 0RR 010
  localparam logic [7:0] OP_HLT = 8'hFF;  // 0000000X halts as well

  localparam logic [7:0] MASK_DST = 8'hC7;
  localparam logic [7:0] MASK_SRC = 8'hF8;
  localparam logic [7:0] MASK_ROT = 8'hE7;

endpackage

// File: design/i8008_top.sv
`timescale 1ns/10ps

module i8008_top import i8008_pkg::*; #(
  parameter int READY_SYNC_STAGES = 2
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] d_in,
  input  logic       ready,
  output logic [7:0] d_out,
  output logic       sync,
  output state_t     state
);

  logic [7:0]  addr_byte;
  logic        pc_inc;
  logic        pc_hi_sel;
  cycle_type_t cyc_type;

  exec_if ex_if ();

  cycle_sequencer #(
    .READY_SYNC_STAGES (READY_SYNC_STAGES)
  ) seq_i (
    .clk,
    .rst,
    .d_in,
    .ready,
    .addr_byte,
    .d_out,
    .sync,
    .state,
    .pc_inc,
    .pc_hi_sel,
    .cyc_type,
    .ex        (ex_if.seq)
  );

  pc_unit pc_i (
    .clk,
    .rst,
    .inc       (pc_inc),
    .hi_sel    (pc_hi_sel),
    .cyc_type,
    .addr_byte
  );

  exec_unit exec_i (
    .clk,
    .rst,
    .ex  (ex_if.exec)
  );

endmodule

// File: design/pc_unit.sv
`timescale 1ns/10ps

module pc_unit import i8008_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        inc,
  input  logic        hi_sel,
  input  cycle_type_t cyc_type,
  output logic [7:0]  addr_byte
);

  logic [ADDR_WIDTH-1:0] pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (inc) begin
      pc <= pc + 1'b1;  // Wraps at the top of the 16 KB space
    end
  end

  // High byte carries the cycle type above PC bits 13:8
  always_comb begin
    if (hi_sel) begin
      addr_byte = {cyc_type, pc[ADDR_WIDTH-1:8]};
    end else begin
      addr_byte = pc[7:0];
    end
  end

  // Increment only at T2, where the high byte is out and the state lasts one clock
  assert property (@(posedge clk) disable iff (rst)
    inc |-> hi_sel ##1 !inc)
    else $error("pc_unit: increment outside T2");

endmodule

// File: design/reg_file.sv
`timescale 1ns/10ps

module reg_file import i8008_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       we,
  input  reg_sel_t   wr_sel,
  input  reg_sel_t   rd_sel,
  input  logic [7:0] wr_data,
  output logic [7:0] rd_data
);

  logic [7:0] regs [7];  // A, B, C, D, E, H, L

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 7; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (we && wr_sel != REG_M) begin
      regs[wr_sel] <= wr_data;
    end
  end

  // M has no storage here
  assign rd_data = (rd_sel == REG_M) ? 8'h00 : regs[rd_sel];

  assert property (@(posedge clk) disable iff (rst)
    we |-> wr_sel != REG_M)
    else $error("reg_file: write with selection M");

endmodule

// File: flist.f
design/i8008_pkg.sv
design/exec_if.sv
design/pc_unit.sv
design/reg_file.sv
design/alu.sv
design/exec_unit.sv
design/cycle_sequencer.sv
design/i8008_top.sv
test/tb_i8008.sv

// File: test/tb_i8008.sv
`timescale 1ns/10ps

module tb_i8008 import i8008_pkg::*; ();

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_PROGRAMS = 6;
  localparam logic [31:0] LFSR_SEED = 32'hf70e0e13;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  logic       clk;
  logic       rst;
  logic [7:0] d_in;
  logic       ready;
  logic [7:0] d_out;
  logic       sync;
  state_t     state;

  logic [7:0] mem [2**ADDR_WIDTH];
  logic [31:0] lfsr;
  logic       stall_on;
  logic [1:0] stretch;
  logic [31:0] stall_bits;

  // Memory model capture
  logic [7:0]            lo_byte;
  logic [7:0]            read_byte;
  logic [ADDR_WIDTH-1:0] cur_addr;
  cycle_type_t           cur_type;
  logic [ADDR_WIDTH-1:0] seen_addr [$];
  logic [7:0]            seen_hi [$];    // Full T2 byte, cycle type on top
  logic [7:0]            seen_wdata [$];

  // Expected machine behavior, built with the program
  int                    prog_ptr;
  logic [7:0]            exp_reg [8];
  logic                  exp_carry;
  logic [ADDR_WIDTH-1:0] exp_addr [$];
  cycle_type_t           exp_type [$];
  logic [7:0]            exp_wdata [$];
  logic [7:0]            opa [8];
  logic [7:0]            opb [8];

  int checks;
  int value_errors;
  int other_errors;
  int wait_checks;

  i8008_top dut_i (
    .clk,
    .rst,
    .d_in,
    .ready,
    .d_out,
    .sync,
    .state
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_PROGRAMS * 400 * CLK_PERIOD);
    $display("Watchdog expired before all programs reached the halt state");
    $display("Something failed");
    $finish;
  end

  // Memory model, address bytes at T1 and T2, data at T3
  initial begin
    d_in = 8'h00;
    read_byte = 8'h00;
    forever begin
      @(posedge clk);
      if (rst) begin
        seen_addr.delete();
        seen_hi.delete();
        seen_wdata.delete();
      end else begin
        case (state)
          T1: lo_byte = d_out;
          T2: begin
            cur_addr = {d_out[5:0], lo_byte};
            cur_type = cycle_type_t'(d_out[7:6]);
            seen_addr.push_back(cur_addr);
            seen_hi.push_back(d_out);
            if (cur_type != PCW) begin
              read_byte = mem[cur_addr];
            end
          end
          T3: begin
            if (cur_type == PCW) begin
              seen_wdata.push_back(d_out);
            end
          end
          default: ;
        endcase
      end
      #1 d_in = read_byte;
    end
  end

  // Ready toggles in random stretches of 1 to 4 clocks while stalling
  initial begin
    ready = 1'b1;
    stretch = 2'd0;
    forever begin
      @(posedge clk);
      #1;
      if (!stall_on) begin
        ready = 1'b1;
        stretch = 2'd0;
      end else if (stretch != 2'd0) begin
        stretch = stretch - 2'd1;
      end else begin
        ready = ~ready;
        stall_bits = rand_bits(2);
        stretch = stall_bits[1:0];
      end
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        bit_out;
    r = '0;
    for (int i = 0; i < n; i++) begin
      bit_out = lfsr[0];
      lfsr = {1'b0, lfsr[31:1]};
      if (bit_out) begin
        lfsr = lfsr ^ LFSR_TAPS;
      end
      r = {r[30:0], bit_out};
    end
    return r;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = rand_bits(8);
    return r[7:0];
  endfunction

  // Returns {carry, result}
  function automatic logic [8:0] alu_expect(input alu_op_t op, input logic [7:0] a,
                                            input logic [7:0] b, input logic cin);
    int sa;
    int sb;
    int r;
    sa = {24'd0, a};
    sb = {24'd0, b};
    case (op)
      ALU_ADD: r = sa + sb;
      ALU_ADC: r = sa + sb + {31'd0, cin};
      ALU_SUB: r = sa - sb;
      ALU_SBB: r = sa - sb - {31'd0, cin};
      ALU_CMP: r = sa - sb;
      default: r = 0;
    endcase
    case (op)
      ALU_ADD, ALU_ADC: return {r > 255, r[7:0]};
      ALU_SUB, ALU_SBB: return {r < 0, r[7:0]};  // Borrow
      ALU_AND: return {1'b0, a & b};
      ALU_XOR: return {1'b0, a ^ b};
      ALU_OR:  return {1'b0, a | b};
      default: return {r < 0, a};                // Compare keeps A
    endcase
  endfunction

  function automatic logic [8:0] rot_expect(input rot_op_t k, input logic [7:0] a,
                                            input logic cin);
    case (k)
      ROT_RLC: return {a[7], a[6:0], a[7]};
      ROT_RRC: return {a[0], a[0], a[7:1]};
      ROT_RAL: return {a[7], a[6:0], cin};
      ROT_RAR: return {a[0], cin, a[7:1]};
      default: return {cin, a};
    endcase
  endfunction

  task automatic check_byte(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("Error at %0d ns: %s expected 8'h%02h, got 8'h%02h",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] expected,
                            input logic [ADDR_WIDTH-1:0] actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("Error at %0d ns: %s expected 14'h%04h, got 14'h%04h",
               $time, name, expected, actual);
    end
  endtask

  task automatic check_state(input string name, input state_t expected, input state_t actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("Error at %0d ns: %s expected %s, got %s",
               $time, name, expected.name(), actual.name());
    end
  endtask

  task automatic new_program();
    logic [ADDR_WIDTH-1:0] a;
    for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
      a = i[ADDR_WIDTH-1:0];
      mem[i] = a[7:0] + {a[13:8], 2'b11};
    end
    for (int r = 0; r < 8; r++) begin
      exp_reg[r] = 8'h00;  // Reset values
    end
    prog_ptr = 0;
    exp_carry = 1'b0;
    exp_addr.delete();
    exp_type.delete();
    exp_wdata.delete();
  endtask

  task automatic emit(input logic [7:0] b, input cycle_type_t t);
    mem[prog_ptr] = b;
    exp_addr.push_back(prog_ptr[ADDR_WIDTH-1:0]);
    exp_type.push_back(t);
    prog_ptr++;
  endtask

  task automatic load_imm(input reg_sel_t r, input logic [7:0] v);
    emit(OP_LRI | {2'b00, r, 3'b000}, PCI);
    emit(v, PCR);
    exp_reg[r] = v;
  endtask

  task automatic copy_reg(input reg_sel_t d, input reg_sel_t s);
    emit(OP_LRR | {2'b00, d, s}, PCI);
    exp_reg[d] = exp_reg[s];
  endtask

  task automatic store_reg(input reg_sel_t s);
    emit(OP_LMR | {5'd0, s}, PCI);
    exp_addr.push_back({exp_reg[REG_H][5:0], exp_reg[REG_L]});
    exp_type.push_back(PCW);
    exp_wdata.push_back(exp_reg[s]);
  endtask

  task automatic alu_reg(input alu_op_t op, input reg_sel_t s);
    emit(OP_ALU | {2'b00, op, s}, PCI);
    {exp_carry, exp_reg[REG_A]} = alu_expect(op, exp_reg[REG_A], exp_reg[s], exp_carry);
  endtask

  task automatic inc_reg(input reg_sel_t r);
    emit(OP_INR | {2'b00, r, 3'b000}, PCI);
    exp_reg[r] = exp_reg[r] + 8'd1;  // Carry kept
  endtask

  task automatic dec_reg(input reg_sel_t r);
    emit(OP_DCR | {2'b00, r, 3'b000}, PCI);
    exp_reg[r] = exp_reg[r] - 8'd1;
  endtask

  task automatic rotate_acc(input rot_op_t k);
    emit(OP_ROT | {2'b00, k, 3'b000}, PCI);
    {exp_carry, exp_reg[REG_A]} = rot_expect(k, exp_reg[REG_A], exp_carry);
  endtask

  task automatic halt_prog();
    emit(OP_HLT, PCI);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1 rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic compare_results();
    int n;
    if (seen_addr.size() != exp_addr.size()) begin
      other_errors++;
      $display("DUT ran %0d machine cycles where %0d were expected",
               seen_addr.size(), exp_addr.size());
    end
    n = (seen_addr.size() < exp_addr.size()) ? seen_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      check_addr("cycle address", exp_addr[i], seen_addr[i]);
      check_byte("d_out at T2", {exp_type[i], exp_addr[i][13:8]}, seen_hi[i]);
    end
    if (seen_wdata.size() != exp_wdata.size()) begin
      other_errors++;
      $display("DUT stored %0d bytes where %0d were expected",
               seen_wdata.size(), exp_wdata.size());
    end
    n = (seen_wdata.size() < exp_wdata.size()) ? seen_wdata.size() : exp_wdata.size();
    for (int i = 0; i < n; i++) begin
      check_byte("store data", exp_wdata[i], seen_wdata[i]);
    end
  endtask

  // Ready seen low three edges back means the synchronized level is low now
  task automatic run_program();
    logic [2:0] rdy_hist;
    state_t     state_prev;
    apply_reset();
    rdy_hist = 3'b111;
    state_prev = T1;
    do begin
      @(posedge clk);
      if (stall_on && (state_prev == T2 || state_prev == WAIT) && !rdy_hist[2]) begin
        check_state("state", WAIT, state);
        wait_checks++;
      end
      rdy_hist = {rdy_hist[1:0], ready};
      state_prev = state;
    end while (state != STOPPED);
    compare_results();
  endtask

  task automatic build_alu_program();
    new_program();
    load_imm(REG_H, 8'h20);
    load_imm(REG_L, 8'h00);
    load_imm(REG_C, 8'h00);  // Zero for the carry readout
    for (int i = 0; i < 8; i++) begin
      if (i == int'(ALU_ADC) || i == int'(ALU_SBB)) begin
        load_imm(REG_A, 8'h80);
        rotate_acc(ROT_RLC);  // Carry in of one
      end
      load_imm(REG_A, opa[i]);
      load_imm(REG_B, opb[i]);
      alu_reg(alu_op_t'(i[2:0]), REG_B);
      store_reg(REG_A);
      inc_reg(REG_L);
      load_imm(REG_A, 8'h00);
      alu_reg(ALU_ADC, REG_C);
      store_reg(REG_A);
      inc_reg(REG_L);
    end
    halt_prog();
  endtask

  task automatic fetch_addressing();
    new_program();
    copy_reg(REG_B, REG_C);
    load_imm(REG_A, rand_byte());
    inc_reg(REG_D);
    alu_reg(ALU_OR, REG_A);
    halt_prog();
    run_program();
  endtask

  task automatic loads_and_store();
    new_program();
    for (int r = 0; r < 7; r++) begin
      load_imm(reg_sel_t'(r[2:0]), rand_byte());
    end
    copy_reg(REG_D, REG_A);
    copy_reg(REG_E, REG_B);
    copy_reg(REG_A, REG_C);
    load_imm(REG_H, 8'h22);
    load_imm(REG_L, 8'h10);
    for (int r = 0; r < 7; r++) begin
      store_reg(reg_sel_t'(r[2:0]));
      inc_reg(REG_L);
    end
    halt_prog();
    run_program();
  endtask

  task automatic alu_operations();
    for (int i = 0; i < 8; i++) begin
      opa[i] = rand_byte();
      opb[i] = rand_byte();
    end
    build_alu_program();
    run_program();
  endtask

  task automatic inc_dec_rotate();
    new_program();
    load_imm(REG_H, 8'h21);
    load_imm(REG_L, 8'h00);
    load_imm(REG_C, 8'h00);
    load_imm(REG_B, 8'hFF);
    load_imm(REG_D, 8'h00);
    load_imm(REG_A, 8'hFF);
    alu_reg(ALU_ADD, REG_B);  // Sets the carry
    inc_reg(REG_B);           // Wraps to 00
    dec_reg(REG_D);           // Wraps to FF
    store_reg(REG_B);
    inc_reg(REG_L);
    store_reg(REG_D);
    inc_reg(REG_L);
    load_imm(REG_A, 8'h00);
    alu_reg(ALU_ADC, REG_C);  // Carry must have survived
    store_reg(REG_A);
    inc_reg(REG_L);
    load_imm(REG_A, rand_byte());
    for (int pass = 0; pass < 2; pass++) begin
      for (int k = 0; k < 4; k++) begin
        rotate_acc(rot_op_t'(k[2:0]));
        store_reg(REG_A);
        inc_reg(REG_L);
      end
    end
    load_imm(REG_A, 8'h00);
    alu_reg(ALU_ADC, REG_C);
    store_reg(REG_A);
    halt_prog();
    run_program();
  endtask

  task automatic ready_stall();
    stall_on = 1'b1;
    wait_checks = 0;
    build_alu_program();  // Same operands as the ALU test
    run_program();
    stall_on = 1'b0;
    if (wait_checks == 0) begin
      other_errors++;
      $display("Ready was never low long enough to hold the DUT in WAIT");
    end
  endtask

  task automatic halt_hold();
    int n;
    new_program();
    load_imm(REG_A, rand_byte());
    halt_prog();
    mem[prog_ptr] = OP_INR | {2'b00, REG_B, 3'b000};  // Must never be fetched
    run_program();
    n = seen_addr.size();
    repeat (50) begin
      @(posedge clk);
      check_state("state", STOPPED, state);
      if (sync) begin
        other_errors++;
        $display("sync went high at %0d ns after the halt", $time);
      end
    end
    if (seen_addr.size() != n) begin
      other_errors++;
      $display("DUT started a new machine cycle after the halt");
    end
  endtask

  initial begin
    rst = 1'b1;
    stall_on = 1'b0;
    lfsr = LFSR_SEED;
    checks = 0;
    value_errors = 0;
    other_errors = 0;
    wait_checks = 0;
    fetch_addressing();
    loads_and_store();
    alu_operations();
    inc_dec_rotate();
    ready_stall();
    halt_hold();
    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
